/* sources.f */
src/core_pkg.sv
src/inst_decoder.sv
src/rename_table.sv
src/phys_reg_file.sv
src/issue_station.sv
src/int_alu.sv
src/seq_multiplier.sv
src/reorder_buffer.sv
src/ooo_core.sv
tb/tb_clock_gen.sv
tb/tb_ooo_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run tb_ooo_core with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ooo_core -f sources.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build returned status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* tb/tb_ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core import core_pkg::*; ();

    logic    clk;
    logic    arst_n;
    logic    inst_valid;
    word_t   inst;
    logic    full;
    logic    commit_valid;
    commit_t commit;

    word_t   rng_state = 32'd44910;
    word_t   model_regs [32];
    commit_t exp_q [$];
    int      acc_q [$];
    logic    lat_q [$];
    int      cycle_no = 0;
    int      commits = 0;
    logic    saw_full = 1'b0;

    tb_clock_gen i_tb_clock_gen (.clk(clk), .arst_n(arst_n));

    ooo_core i_ooo_core (
        .clk(clk), .arst_n(arst_n), .inst_valid(inst_valid), .inst(inst),
        .full(full), .commit_valid(commit_valid), .commit(commit)
    );

    function automatic word_t xorshift32(word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic word_t rand_below(int n);
        return rand_word() % word_t'(n);
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, areg_t rs2, areg_t rs1, logic [2:0] f3,
                                    areg_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, areg_t rs1, logic [2:0] f3, areg_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t enc_lui(logic [19:0] imm, areg_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // small register set so dependences come up often
    function automatic word_t random_alu_inst();
        word_t r;
        word_t kind;
        word_t sel;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
        kind = rand_below(5);
        sel  = rand_below(10);
        r    = rand_word();
        rd   = areg_t'(1 + rand_below(7));
        rs1  = areg_t'(rand_below(8));
        rs2  = areg_t'(rand_below(8));
        if (kind < 2) begin
            case (sel)
                0, 1:    f3 = 3'b000;
                2:       f3 = 3'b001;
                3:       f3 = 3'b010;
                4:       f3 = 3'b011;
                5:       f3 = 3'b100;
                6, 7:    f3 = 3'b101;
                8:       f3 = 3'b110;
                default: f3 = 3'b111;
            endcase
            f7 = (sel == 1 || sel == 7) ? 7'b0100000 : 7'b0000000;
            return enc_r(f7, rs2, rs1, f3, rd);
        end else if (kind < 4) begin
            f3  = r[14:12];
            imm = r[11:0];
            if (f3 == 3'b001)
                imm[11:5] = 7'b0;
            if (f3 == 3'b101)
                imm[11:5] = r[20] ? 7'b0100000 : 7'b0000000;   // srai or srli
            return enc_i(imm, rs1, f3, rd);
        end
        return enc_lui(r[31:12], rd);
    endfunction

    function automatic word_t random_mul();
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
        rd  = areg_t'(1 + rand_below(7));
        rs1 = areg_t'(1 + rand_below(7));
        rs2 = areg_t'(1 + rand_below(7));
        return enc_r(7'b0000001, rs2, rs1, 3'b000, rd);
    endfunction

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic stop_run(string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_word(string name, word_t got, word_t exp);
        if (got !== exp)
            stop_run($sformatf("FAILED %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp));
    endtask

    task automatic expect_level(string name, logic got, logic exp);
        if (got !== exp)
            stop_run($sformatf("FAILED %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic verify_commit(commit_t got, commit_t exp);
        if (got.rd !== exp.rd)
            stop_run($sformatf("FAILED %0t commit.rd got %0d expected %0d",
                               $time, got.rd, exp.rd));
        else
            compare_word("commit.value", got.value, exp.value);
    endtask

    // in-order ISA model run once per accepted instruction
    task automatic model_accept(input word_t w);
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        areg_t rd;
        word_t a;
        word_t b;
        word_t imm;
        word_t res;
        logic ok;
        commit_t exp;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        rd  = w[11:7];
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        imm = {{20{w[31]}}, w[31:20]};
        ok  = 1'b0;
        res = '0;
        case (opc)
            7'b0110011: begin
                if (f7 == 7'b0000000) begin
                    ok  = 1'b1;
                    res = alu_ref(f3, 1'b0, a, b);
                end else if (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)) begin
                    ok  = 1'b1;
                    res = alu_ref(f3, 1'b1, a, b);
                end else if (f7 == 7'b0000001 && f3 == 3'b000) begin
                    ok  = 1'b1;
                    res = a * b;   // low half
                end
            end
            7'b0010011: begin
                if (f3 == 3'b001)
                    ok = f7 == 7'b0;
                else if (f3 == 3'b101)
                    ok = f7 == 7'b0 || f7 == 7'b0100000;
                else
                    ok = 1'b1;
                res = alu_ref(f3, f3 == 3'b101 && f7[5], a, imm);
            end
            7'b0110111: begin
                ok  = 1'b1;
                res = {w[31:12], 12'b0};
            end
            default: ;
        endcase
        if (ok && rd != '0) begin
            model_regs[rd] = res;
            exp = '{rd: rd, value: res};
        end else begin
            exp = '{rd: '0, value: '0};
        end
        exp_q.push_back(exp);
        acc_q.push_back(cycle_no);
        lat_q.push_back(ok && rd != '0);
    endtask

    task automatic sample_commit();
        commit_t exp;
        int acc;
        logic lat;
        if (commit_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_run("a commit appeared with no instruction outstanding");
            end else begin
                exp = exp_q.pop_front();
                acc = acc_q.pop_front();
                lat = lat_q.pop_front();
                verify_commit(commit, exp);
                if (lat && cycle_no - acc < 3)
                    stop_run($sformatf("commit of x%0d came %0d cycles after acceptance",
                                       exp.rd, cycle_no - acc));
                commits++;
            end
        end else if (commit_valid !== 1'b0) begin
            stop_run("commit_valid is unknown");
        end
    endtask

    // one clock of commit sampling, driving and the accept decision
    task automatic step(input logic valid, input word_t word, output logic taken);
        @(negedge clk);
        cycle_no++;
        sample_commit();
        inst_valid = valid;
        inst       = word;
        #10;
        taken = valid && full === 1'b0;
        if (full === 1'b1)
            saw_full = 1'b1;
        if (taken)
            model_accept(word);
    endtask

    task automatic send(input word_t w);
        int n;
        logic taken;
        n     = 0;
        taken = 1'b0;
        while (!taken && n < 1000) begin
            step(1'b1, w, taken);
            n++;
        end
        if (!taken)
            stop_run("timed out waiting for full to drop");
    endtask

    task automatic drain(input int limit);
        int n;
        logic taken;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            step(1'b0, '0, taken);
            n++;
        end
        if (exp_q.size() != 0)
            stop_run("timed out waiting for outstanding instructions to commit");
    endtask

    initial begin
        int n;
        logic taken;
        inst_valid = 1'b0;
        inst       = '0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        n = 0;
        while (arst_n !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (arst_n !== 1'b1)
            stop_run("timed out waiting for reset release");

        // idle after reset
        expect_level("commit_valid", commit_valid, 1'b0);
        expect_level("full", full, 1'b0);
        for (int i = 0; i < 10; i++) begin
            step(1'b0, '0, taken);
            expect_level("full", full, 1'b0);
        end

        for (int i = 0; i < 300; i++)
            send(random_alu_inst());
        drain(500);

        // mul overtaken by independent work and followed by consumers
        send(enc_lui(20'h12345, 5'd1));
        send(enc_i(12'hff9, 5'd0, 3'b000, 5'd2));
        send(enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd8));
        send(enc_r(7'b0000000, 5'd4, 5'd3, 3'b000, 5'd10));
        send(enc_i(12'h055, 5'd5, 3'b100, 5'd11));
        send(enc_r(7'b0100000, 5'd11, 5'd10, 3'b000, 5'd12));
        send(enc_r(7'b0000000, 5'd1, 5'd8, 3'b000, 5'd13));
        send(enc_r(7'b0000001, 5'd8, 5'd8, 3'b000, 5'd14));
        send(enc_r(7'b0000000, 5'd13, 5'd14, 3'b111, 5'd15));
        drain(500);

        // mul burst where rejected offers are dropped and never retried
        saw_full = 1'b0;
        for (int i = 0; i < 40; i++)
            step(1'b1, random_mul(), taken);
        if (saw_full !== 1'b1)
            stop_run("full never rose during the mul burst");
        drain(3000);

        // rd 0 and unsupported encodings before reads of x0
        send(enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd0));
        send(enc_i(12'h123, 5'd1, 3'b000, 5'd0));
        send(enc_lui(20'hfffff, 5'd0));
        send(enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd0));
        send(32'h0000_2083);   // lw
        send(32'h0020_8463);   // beq
        send(enc_r(7'b0000001, 5'd2, 5'd1, 3'b001, 5'd3));
        send(enc_r(7'b0100000, 5'd2, 5'd1, 3'b001, 5'd4));
        send(enc_i(12'h401, 5'd1, 3'b001, 5'd5));
        send(32'h0000_0073);
        send(32'hffff_ffff);
        send(enc_r(7'b0000000, 5'd0, 5'd0, 3'b000, 5'd5));
        send(enc_i(12'h07b, 5'd0, 3'b000, 5'd6));
        send(enc_r(7'b0000000, 5'd1, 5'd0, 3'b110, 5'd7));
        send(enc_i(12'hfff, 5'd0, 3'b100, 5'd9));
        drain(500);

        $display("%0d instructions committed", commits);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    // held low for 4 rising edges, released away from the edge
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* src/ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core import core_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    inst_valid,
    input  word_t   inst,
    output logic    full,
    output logic    commit_valid,
    output commit_t commit
);

    decoded_t  dec;
    preg_t     src1_tag;
    preg_t     src2_tag;
    preg_t     new_tag;
    preg_t     old_tag;
    logic      free_empty;
    logic      free_valid;
    preg_t     free_tag;
    word_t     rd_val1;
    word_t     rd_val2;
    logic      rd_rdy1;
    logic      rd_rdy2;
    rob_idx_t  tail;
    logic      rob_full;
    logic      alu_full;
    logic      mul_full;
    logic      accept;
    logic      alu_put;
    logic      mul_put;
    rs_entry_t entry;
    logic      alu_issue_valid;
    issue_t    alu_issue;
    logic      mul_issue_valid;
    issue_t    mul_issue;
    logic      mul_busy;
    wb_t       alu_wb;
    wb_t       mul_wb;

    assign full = rob_full || free_empty ||
                  (dec.unit == unit_alu && alu_full) ||
                  (dec.unit == unit_mul && mul_full);
    assign accept = inst_valid && !full;

    // rd 0 and nops skip the stations, the ROB retires them as done
    assign alu_put = accept && dec.wr_rd && dec.unit == unit_alu;
    assign mul_put = accept && dec.wr_rd && dec.unit == unit_mul;

    assign entry = '{op: dec.alu_op, tag: new_tag, rob: tail,
                     val1: rd_val1, tag1: src1_tag, rdy1: rd_rdy1,
                     val2: dec.use_imm ? dec.imm : rd_val2,
                     tag2: dec.use_imm ? preg_t'(0) : src2_tag,
                     rdy2: dec.use_imm || rd_rdy2};

    inst_decoder i_inst_decoder (.inst(inst), .dec(dec));

    rename_table i_rename_table (
        .clk(clk), .arst_n(arst_n), .alloc(accept),
        .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
        .src1_tag(src1_tag), .src2_tag(src2_tag), .new_tag(new_tag), .old_tag(old_tag),
        .free_empty(free_empty), .free_valid(free_valid), .free_tag(free_tag)
    );

    phys_reg_file i_phys_reg_file (
        .clk(clk), .arst_n(arst_n), .alloc(accept && dec.wr_rd), .alloc_tag(new_tag),
        .rd_tag1(src1_tag), .rd_tag2(src2_tag), .rd_val1(rd_val1), .rd_val2(rd_val2),
        .rd_rdy1(rd_rdy1), .rd_rdy2(rd_rdy2), .alu_wb(alu_wb), .mul_wb(mul_wb)
    );

    issue_station alu_station (
        .clk(clk), .arst_n(arst_n), .put(alu_put), .entry(entry), .station_full(alu_full),
        .accept(1'b1), .issue_valid(alu_issue_valid), .issue(alu_issue),
        .alu_wb(alu_wb), .mul_wb(mul_wb)
    );

    issue_station mul_station (
        .clk(clk), .arst_n(arst_n), .put(mul_put), .entry(entry), .station_full(mul_full),
        .accept(!mul_busy), .issue_valid(mul_issue_valid), .issue(mul_issue),
        .alu_wb(alu_wb), .mul_wb(mul_wb)
    );

    int_alu i_int_alu (
        .clk(clk), .arst_n(arst_n), .issue_valid(alu_issue_valid), .issue(alu_issue),
        .wb(alu_wb)
    );

    seq_multiplier i_seq_multiplier (
        .clk(clk), .arst_n(arst_n), .start(mul_issue_valid), .issue(mul_issue),
        .busy(mul_busy), .wb(mul_wb)
    );

    reorder_buffer i_reorder_buffer (
        .clk(clk), .arst_n(arst_n), .alloc(accept), .rd(dec.rd), .old_tag(old_tag),
        .has_rd(dec.wr_rd), .tail(tail), .rob_full(rob_full),
        .alu_wb(alu_wb), .mul_wb(mul_wb), .commit_valid(commit_valid), .commit(commit),
        .free_valid(free_valid), .free_tag(free_tag)
    );

endmodule

`default_nettype wire

/* src/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import core_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     alloc,
    input  areg_t    rd,
    input  preg_t    old_tag,
    input  logic     has_rd,
    output rob_idx_t tail,
    output logic     rob_full,
    input  wb_t      alu_wb,
    input  wb_t      mul_wb,
    output logic     commit_valid,
    output commit_t  commit,
    output logic     free_valid,
    output preg_t    free_tag
);

    rob_idx_t head;
    logic [$clog2(rob_depth):0] count;
    areg_t rd_q  [rob_depth];
    preg_t old_q [rob_depth];
    word_t val_q [rob_depth];
    logic [rob_depth-1:0] has_q;
    logic [rob_depth-1:0] done_q;

    assign rob_full     = count == rob_depth;
    assign commit_valid = count != '0 && done_q[head];
    assign commit       = '{rd: rd_q[head], value: has_q[head] ? val_q[head] : '0};
    assign free_valid   = commit_valid && has_q[head];
    assign free_tag     = old_q[head];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc)
                tail <= tail + 1'b1;
            if (commit_valid)
                head <= head + 1'b1;
            count <= count + alloc - commit_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail]   <= rd;
            old_q[tail]  <= old_tag;
            has_q[tail]  <= has_rd;
            done_q[tail] <= !has_rd;   // nothing to wait for
        end
        if (alu_wb.valid) begin
            done_q[alu_wb.rob] <= 1'b1;
            val_q[alu_wb.rob]  <= alu_wb.data;
        end
        if (mul_wb.valid) begin
            done_q[mul_wb.rob] <= 1'b1;
            val_q[mul_wb.rob]  <= mul_wb.data;
        end
    end

endmodule

`default_nettype wire

/* src/seq_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_multiplier import core_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   start,
    input  issue_t issue,
    output logic   busy,
    output wb_t    wb
);

    typedef enum logic {idle, run} state_e;

    state_e   state;
    logic [$clog2(mul_cycles)-1:0] cnt;
    logic     done_q;
    word_t    mcand;
    word_t    mplier;
    word_t    acc;
    word_t    src_a;
    word_t    src_b;
    word_t    src_acc;
    word_t    next_acc;
    preg_t    tag_q;
    rob_idx_t rob_q;

    assign busy = state == run;

    // first step runs in the start cycle straight from the issue bus
    always_comb begin
        if (state == run) begin
            src_a   = mcand;
            src_b   = mplier;
            src_acc = acc;
        end else begin
            src_a   = issue.a;
            src_b   = issue.b;
            src_acc = '0;
        end
        next_acc = src_acc + (src_b[0] ? src_a : '0);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= idle;
            cnt    <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state <= run;
                        cnt   <= 1'b1;
                    end
                end
                run: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == mul_cycles - 1) begin   // last partial product
                        state  <= idle;
                        done_q <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (busy || start) begin
            acc    <= next_acc;
            mcand  <= src_a << 1;
            mplier <= src_b >> 1;
        end
        if (start && !busy) begin
            tag_q <= issue.tag;
            rob_q <= issue.rob;
        end
    end

    assign wb = '{valid: done_q, tag: tag_q, rob: rob_q, data: acc};

endmodule

`default_nettype wire

/* src/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module int_alu import core_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   issue_valid,
    input  issue_t issue,
    output wb_t    wb
);

    word_t    result;
    word_t    data_q;
    preg_t    tag_q;
    rob_idx_t rob_q;
    logic     valid_q;

    always_comb begin
        case (issue.op)
            op_add:    result = issue.a + issue.b;
            op_sub:    result = issue.a - issue.b;
            op_sll:    result = issue.a << issue.b[4:0];
            op_slt:    result = word_t'($signed(issue.a) < $signed(issue.b));
            op_sltu:   result = word_t'(issue.a < issue.b);
            op_xor:    result = issue.a ^ issue.b;
            op_srl:    result = issue.a >> issue.b[4:0];
            op_sra:    result = word_t'($signed(issue.a) >>> issue.b[4:0]);
            op_or:     result = issue.a | issue.b;
            op_and:    result = issue.a & issue.b;
            op_pass_b: result = issue.b;   // lui
            default:   result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            valid_q <= 1'b0;
        else
            valid_q <= issue_valid;
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            data_q <= result;
            tag_q  <= issue.tag;
            rob_q  <= issue.rob;
        end
    end

    assign wb = '{valid: valid_q, tag: tag_q, rob: rob_q, data: data_q};

endmodule

`default_nettype wire

/* src/issue_station.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_station import core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      put,
    input  rs_entry_t entry,
    output logic      station_full,
    input  logic      accept,
    output logic      issue_valid,
    output issue_t    issue,
    input  wb_t       alu_wb,
    input  wb_t       mul_wb
);

    typedef logic [$clog2(rs_depth)-1:0] slot_t;

    rs_entry_t slots [rs_depth];
    logic [rs_depth-1:0] used;
    slot_t put_idx;
    slot_t pick_idx;
    logic  pick_ok;

    // grab an operand when its tag shows up on the bus
    function automatic rs_entry_t snoop(rs_entry_t e, wb_t wb);
        if (!e.rdy1 && wb.valid && wb.tag == e.tag1) begin
            e.val1 = wb.data;
            e.rdy1 = 1'b1;
        end
        if (!e.rdy2 && wb.valid && wb.tag == e.tag2) begin
            e.val2 = wb.data;
            e.rdy2 = 1'b1;
        end
        return e;
    endfunction

    assign station_full = &used;

    // walk downward so the lowest index ends up chosen
    always_comb begin
        put_idx  = '0;
        pick_idx = '0;
        pick_ok  = 1'b0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!used[i])
                put_idx = slot_t'(i);
            if (used[i] && slots[i].rdy1 && slots[i].rdy2) begin
                pick_idx = slot_t'(i);
                pick_ok  = 1'b1;
            end
        end
    end

    assign issue_valid = accept && pick_ok;
    assign issue = '{op: slots[pick_idx].op, a: slots[pick_idx].val1, b: slots[pick_idx].val2,
                     tag: slots[pick_idx].tag, rob: slots[pick_idx].rob};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            used <= '0;
        end else begin
            if (put)
                used[put_idx] <= 1'b1;
            if (issue_valid)
                used[pick_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++)
            slots[i] <= snoop(snoop(slots[i], alu_wb), mul_wb);
        if (put)
            slots[put_idx] <= entry;   // operands already bypassed by the register file
    end

endmodule

`default_nettype wire

/* src/phys_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module phys_reg_file import core_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  alloc,
    input  preg_t alloc_tag,
    input  preg_t rd_tag1,
    input  preg_t rd_tag2,
    output word_t rd_val1,
    output word_t rd_val2,
    output logic  rd_rdy1,
    output logic  rd_rdy2,
    input  wb_t   alu_wb,
    input  wb_t   mul_wb
);

    word_t regs [phys_regs];
    logic [phys_regs-1:0] rdy;

    // writeback of this cycle wins over the array
    function automatic logic [xlen:0] read_port(preg_t tag);
        if (alu_wb.valid && alu_wb.tag == tag)
            return {1'b1, alu_wb.data};
        if (mul_wb.valid && mul_wb.tag == tag)
            return {1'b1, mul_wb.data};
        return {rdy[tag], regs[tag]};
    endfunction

    always_comb begin
        {rd_rdy1, rd_val1} = read_port(rd_tag1);
        {rd_rdy2, rd_val2} = read_port(rd_tag2);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < phys_regs; i++)
                regs[i] <= '0;
            rdy <= '1;
        end else begin
            if (alloc)
                rdy[alloc_tag] <= 1'b0;   // pending until writeback
            if (alu_wb.valid) begin
                regs[alu_wb.tag] <= alu_wb.data;
                rdy[alu_wb.tag]  <= 1'b1;
            end
            if (mul_wb.valid) begin
                regs[mul_wb.tag] <= mul_wb.data;
                rdy[mul_wb.tag]  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/rename_table.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_table import core_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  alloc,
    input  areg_t rs1,
    input  areg_t rs2,
    input  areg_t rd,
    output preg_t src1_tag,
    output preg_t src2_tag,
    output preg_t new_tag,
    output preg_t old_tag,
    output logic  free_empty,
    input  logic  free_valid,
    input  preg_t free_tag
);

    typedef logic [$clog2(phys_regs-arch_regs)-1:0] fptr_t;

    preg_t map [arch_regs];
    preg_t free_fifo [phys_regs-arch_regs];
    fptr_t rd_ptr;
    fptr_t wr_ptr;
    logic [$clog2(phys_regs-arch_regs):0] free_cnt;
    logic  pop;

    assign src1_tag   = map[rs1];
    assign src2_tag   = map[rs2];
    assign old_tag    = map[rd];
    assign new_tag    = free_fifo[rd_ptr];
    assign free_empty = free_cnt == '0;
    assign pop        = alloc && rd != '0;   // x0 stays on tag 0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < arch_regs; i++)
                map[i] <= preg_t'(i);
            for (int i = 0; i < phys_regs - arch_regs; i++)
                free_fifo[i] <= preg_t'(arch_regs + i);
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            free_cnt <= ($clog2(phys_regs-arch_regs)+1)'(phys_regs - arch_regs);
        end else begin
            if (pop) begin
                map[rd] <= new_tag;
                rd_ptr  <= rd_ptr + 1'b1;
            end
            if (free_valid) begin
                free_fifo[wr_ptr] <= free_tag;   // returned at commit
                wr_ptr            <= wr_ptr + 1'b1;
            end
            free_cnt <= free_cnt + free_valid - pop;
        end
    end

endmodule

`default_nettype wire

/* src/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import core_pkg::*; (
    input  word_t    inst,
    output decoded_t dec
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    alu_op_e    f3_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // same funct3 map for OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  f3_op = op_add;
            3'b001:  f3_op = op_sll;
            3'b010:  f3_op = op_slt;
            3'b011:  f3_op = op_sltu;
            3'b100:  f3_op = op_xor;
            3'b101:  f3_op = funct7[5] ? op_sra : op_srl;
            3'b110:  f3_op = op_or;
            default: f3_op = op_and;
        endcase
    end

    always_comb begin
        dec = '0;
        case (opcode)
            7'b0110011: begin
                if (funct7 == 7'b0000001) begin
                    if (funct3 == 3'b000)
                        dec.unit = unit_mul;   // mul, low half only
                end else if (funct7 == 7'b0000000) begin
                    dec.unit = unit_alu;
                end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
                    dec.unit = unit_alu;
                end
                dec.alu_op = (funct3 == 3'b000 && funct7[5]) ? op_sub : f3_op;
                dec.rs1    = inst[19:15];
                dec.rs2    = inst[24:20];
            end
            7'b0010011: begin
                if (!(funct3 == 3'b001 && funct7 != 7'b0) &&
                    !(funct3 == 3'b101 && funct7 != 7'b0 && funct7 != 7'b0100000))
                    dec.unit = unit_alu;
                dec.alu_op  = f3_op;
                dec.rs1     = inst[19:15];
                dec.use_imm = 1'b1;
                dec.imm     = {{20{inst[31]}}, inst[31:20]};
            end
            7'b0110111: begin   // lui
                dec.unit    = unit_alu;
                dec.alu_op  = op_pass_b;
                dec.use_imm = 1'b1;
                dec.imm     = {inst[31:12], 12'b0};
            end
            default: ;
        endcase
        if (dec.unit == unit_none) begin
            dec = '0;   // anything else is a nop
        end else begin
            dec.rd    = inst[11:7];
            dec.wr_rd = inst[11:7] != '0;
        end
    end

endmodule

`default_nettype wire

/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int xlen       = 32;
    localparam int arch_regs  = 32;
    localparam int phys_regs  = 64;
    localparam int rob_depth  = 16;
    localparam int rs_depth   = 4;
    localparam int mul_cycles = 32;

    typedef logic [xlen-1:0]              word_t;
    typedef logic [$clog2(arch_regs)-1:0] areg_t;
    typedef logic [$clog2(phys_regs)-1:0] preg_t;
    typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;

    typedef enum logic [1:0] {unit_none, unit_alu, unit_mul} unit_e;

    typedef enum logic [3:0] {
        op_add, op_sub, op_sll, op_slt, op_sltu, op_xor,
        op_srl, op_sra, op_or, op_and, op_pass_b
    } alu_op_e;

    typedef struct packed {
        unit_e   unit;
        alu_op_e alu_op;
        areg_t   rs1;
        areg_t   rs2;
        areg_t   rd;
        logic    use_imm;   // operand b comes from imm
        word_t   imm;
        logic    wr_rd;     // rd is nonzero and written
    } decoded_t;

    typedef struct packed {
        alu_op_e  op;
        preg_t    tag;
        rob_idx_t rob;
        word_t    val1;
        preg_t    tag1;
        logic     rdy1;
        word_t    val2;
        preg_t    tag2;
        logic     rdy2;
    } rs_entry_t;

    typedef struct packed {
        alu_op_e  op;
        word_t    a;
        word_t    b;
        preg_t    tag;
        rob_idx_t rob;
    } issue_t;

    typedef struct packed {
        logic     valid;
        preg_t    tag;
        rob_idx_t rob;
        word_t    data;
    } wb_t;

    typedef struct packed {
        areg_t rd;
        word_t value;
    } commit_t;

endpackage

`default_nettype wire
